/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
logic/mem_pkg.sv
logic/boot_loader.sv
logic/mem_arbiter.sv
logic/burst_ram.sv
logic/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

/* logic/boot_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_loader import mem_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    // Request towards the arbiter, always a write
    output mem_req_t req,
    output word_t    write,
    input  wire      write_req,
    input  wire      last,

    // External flash source, answers in the same cycle
    output addr_t    flash_index,
    input  word_t    flash_word,

    output logic     boot_done
);

    // Block being copied
    logic [BLK_W-1:0] blk_q;
    // Word offset inside the current block
    offs_t            beat_q;
    // Burst request pending
    logic             op_q;
    logic             done_q;

    ////////////////////////////////////////////////////////////
    // Copy sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_q  <= '0;
            beat_q <= '0;
            op_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // One word taken per write strobe, wraps to 0 after the last beat
            if (write_req) begin
                beat_q <= beat_q + 1'b1;
            end

            if (last) begin
                // Drop request for one cycle after each burst
                op_q <= 1'b0;
                if (blk_q == BLK_W'(BOOT_BLOCKS - 1)) begin
                    done_q <= 1'b1;
                end else begin
                    blk_q <= blk_q + 1'b1;
                end
            end else if (!op_q && !done_q) begin
                // Start next block, also the first one out of reset
                op_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        req.op   = op_q;
        req.rw   = 1'b1;
        req.addr = {blk_q, offs_t'(0)};
    end

    // Flash index doubles as RAM word address
    assign flash_index = {blk_q, beat_q};

    // Flash word goes straight onto the write bus
    assign write = flash_word;

    assign boot_done = done_q;

endmodule

`default_nettype wire

/* logic/burst_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_ram import mem_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    // Steered request from the arbiter
    input  mem_req_t req,
    input  word_t    write,

    output word_t    read,
    output logic     read_valid,
    output logic     write_req,
    output logic     last
);

    // Main storage, contents kept over reset
    word_t mem [0:(2**ADDR_W)-1];

    // Burst sequencer
    logic  busy_q;
    // Burst finished, waiting for op to drop
    logic  done_q;
    offs_t beat_q;

    logic             start;
    logic [BLK_W-1:0] blk;
    addr_t            beat_addr;
    addr_t            read_addr;
    logic             load_read;
    word_t            read_q;

    ////////////////////////////////////////////////////////////
    // Beat decode
    ////////////////////////////////////////////////////////////

    // New burst seen in its first granted cycle
    assign start = req.op && !busy_q && !done_q;

    // Offset bits of the request ignored
    assign blk       = req.addr[ADDR_W-1:OFFS_W];
    assign beat_addr = {blk, beat_q};

    // Fetch one word ahead so it is registered for the next beat
    assign read_addr = start ? {blk, offs_t'(0)} : {blk, offs_t'(beat_q + 1'b1)};
    assign load_read = !req.rw &&
                       (start || (busy_q && beat_q != offs_t'(LAST_BEAT)));

    assign read_valid = busy_q && !req.rw;
    assign write_req  = busy_q && req.rw;
    assign last       = busy_q && (beat_q == offs_t'(LAST_BEAT));
    assign read       = read_q;

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            beat_q <= '0;
        end else begin
            if (start) begin
                // First beat follows one cycle after the request
                busy_q <= 1'b1;
                beat_q <= '0;
            end else if (busy_q) begin
                if (beat_q == offs_t'(LAST_BEAT)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end else if (done_q && !req.op) begin
                // Ready again once the grant is gone
                done_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Master drives the word for this offset during write_req
        if (write_req) begin
            mem[beat_addr] <= write;
        end
        if (load_read) begin
            read_q <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    // Boot loader, write only
    input  mem_req_t boot_req,
    input  word_t    boot_write,
    output logic     boot_write_req,
    output logic     boot_last,

    // Instruction cache, read only
    input  mem_req_t imem_req,
    output word_t    imem_read,
    output logic     imem_read_valid,
    output logic     imem_last,

    // Data cache, read or write back
    input  mem_req_t dmem_req,
    input  word_t    dmem_write,
    output logic     dmem_write_req,
    output word_t    dmem_read,
    output logic     dmem_read_valid,
    output logic     dmem_last,

    // Burst RAM
    output mem_req_t mem_req,
    output word_t    mem_write,
    input  word_t    mem_read,
    input  wire      mem_read_valid,
    input  wire      mem_write_req,
    input  wire      mem_last
);

    arb_state_t state_q;

    ////////////////////////////////////////////////////////////
    // Grant register
    ////////////////////////////////////////////////////////////

    // Priority boot, then instruction, then data
    // Grant held for the whole burst, released on RAM last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (boot_req.op) begin
                        state_q <= ARB_BOOT;
                    end else if (imem_req.op) begin
                        state_q <= ARB_INST;
                    end else if (dmem_req.op) begin
                        state_q <= ARB_DATA;
                    end
                end
                ARB_BOOT, ARB_INST, ARB_DATA: begin
                    if (mem_last) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Steering
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Nobody owns the RAM, every strobe quiet
        mem_req         = '0;
        mem_write       = '0;
        boot_write_req  = 1'b0;
        boot_last       = 1'b0;
        imem_read       = '0;
        imem_read_valid = 1'b0;
        imem_last       = 1'b0;
        dmem_write_req  = 1'b0;
        dmem_read       = '0;
        dmem_read_valid = 1'b0;
        dmem_last       = 1'b0;

        case (state_q)
            ARB_BOOT: begin
                // Boot loader only writes
                mem_req        = boot_req;
                mem_req.rw     = 1'b1;
                mem_write      = boot_write;
                boot_write_req = mem_write_req;
                boot_last      = mem_last;
            end
            ARB_INST: begin
                // Instruction refill only reads
                mem_req         = imem_req;
                mem_req.rw      = 1'b0;
                imem_read       = mem_read;
                imem_read_valid = mem_read_valid;
                imem_last       = mem_last;
            end
            ARB_DATA: begin
                mem_req         = dmem_req;
                mem_write       = dmem_write;
                dmem_write_req  = mem_write_req;
                dmem_read       = mem_read;
                dmem_read_valid = mem_read_valid;
                dmem_last       = mem_last;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    // One memory word
    localparam int DATA_W = 32;

    // Word address into RAM, 4096 words
    localparam int ADDR_W = 12;

    // Words moved by one burst, same as a cache block
    localparam int BLOCK_WORDS = 8;
    localparam int OFFS_W = $clog2(BLOCK_WORDS);

    // Offset of the final beat in a burst
    localparam int LAST_BEAT = BLOCK_WORDS - 1;

    // Block number field of an address
    localparam int BLK_W = ADDR_W - OFFS_W;

    // Boot image is blocks 0 to 3, words 0 to 31
    localparam int BOOT_BLOCKS = 4;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0] word_t;

    // Upper bits block number, low OFFS_W bits block offset
    typedef logic [ADDR_W-1:0] addr_t;

    // Beat counter inside a burst
    typedef logic [OFFS_W-1:0] offs_t;

    // Request from a master, held until its last strobe
    typedef struct packed {
        logic  op;      // Request active
        logic  rw;      // High for a write burst
        addr_t addr;    // Block address, offset bits ignored
    } mem_req_t;

    // Current owner of the RAM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BOOT,
        ARB_INST,
        ARB_DATA
    } arb_state_t;

endpackage

`default_nettype wire

/* logic/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem import mem_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    // Instruction-cache refill port
    input  mem_req_t imem_req,
    output word_t    imem_read,
    output logic     imem_read_valid,
    output logic     imem_last,

    // Data-cache port
    input  mem_req_t dmem_req,
    input  word_t    dmem_write,
    output logic     dmem_write_req,
    output word_t    dmem_read,
    output logic     dmem_read_valid,
    output logic     dmem_last,

    // External flash source
    output addr_t    flash_index,
    input  word_t    flash_word,

    output logic     boot_done
);

    // Boot loader to arbiter
    mem_req_t boot_req;
    word_t    boot_write;
    logic     boot_write_req;
    logic     boot_last;

    // Arbiter to RAM
    mem_req_t mem_req;
    word_t    mem_write;
    word_t    mem_read;
    logic     mem_read_valid;
    logic     mem_write_req;
    logic     mem_last;

    boot_loader boot_loader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (boot_req),
        .write       (boot_write),
        .write_req   (boot_write_req),
        .last        (boot_last),
        .flash_index (flash_index),
        .flash_word  (flash_word),
        .boot_done   (boot_done)
    );

    mem_arbiter mem_arbiter_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .boot_req        (boot_req),
        .boot_write      (boot_write),
        .boot_write_req  (boot_write_req),
        .boot_last       (boot_last),
        .imem_req        (imem_req),
        .imem_read       (imem_read),
        .imem_read_valid (imem_read_valid),
        .imem_last       (imem_last),
        .dmem_req        (dmem_req),
        .dmem_write      (dmem_write),
        .dmem_write_req  (dmem_write_req),
        .dmem_read       (dmem_read),
        .dmem_read_valid (dmem_read_valid),
        .dmem_last       (dmem_last),
        .mem_req         (mem_req),
        .mem_write       (mem_write),
        .mem_read        (mem_read),
        .mem_read_valid  (mem_read_valid),
        .mem_write_req   (mem_write_req),
        .mem_last        (mem_last)
    );

    burst_ram burst_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (mem_req),
        .write      (mem_write),
        .read       (mem_read),
        .read_valid (mem_read_valid),
        .write_req  (mem_write_req),
        .last       (mem_last)
    );

endmodule

`default_nettype wire

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem import mem_pkg::*; ();

    localparam logic [31:0] SEED = 32'h3bc4b2a3;
    localparam int NUM_BLOCKS = 2 ** BLK_W;
    localparam int RAND_PAIRS = 4;
    // Boot, boot-time pair, image reads, write/read pairs, overwrite pair, same-cycle pair
    localparam int NUM_BURSTS = BOOT_BLOCKS + 2 + BOOT_BLOCKS + 2 * RAND_PAIRS + 2 + 2;
    localparam int TIMEOUT_CYCLES = 20 * NUM_BURSTS * 12;
    // Edges from request to the edge that samples last
    localparam int LATENCY = BLOCK_WORDS + 2;

    logic     clk;
    logic     rst_n;
    mem_req_t imem_req;
    word_t    imem_read;
    logic     imem_read_valid;
    logic     imem_last;
    mem_req_t dmem_req;
    word_t    dmem_write;
    logic     dmem_write_req;
    word_t    dmem_read;
    logic     dmem_read_valid;
    logic     dmem_last;
    addr_t    flash_index;
    word_t    flash_word;
    logic     boot_done;

    // RAM model
    word_t shadow [0:(2**ADDR_W)-1];

    int    cycle_cnt = 0;
    offs_t ibeat = '0;
    offs_t dbeat = '0;
    // Written by the compare process only
    int    i_last_cnt = 0;
    int    d_last_cnt = 0;
    int    i_last_cyc = 0;
    int    d_last_cyc = 0;
    logic  i_done = 1'b0;
    logic  d_done = 1'b0;
    logic  boot_seen = 1'b0;
    // Written by the stimulus only
    int    i_mark;
    int    d_mark;
    int    i_req_cyc;
    int    d_req_cyc;
    int    last_blk;

    mem_subsystem mem_subsystem_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .imem_req        (imem_req),
        .imem_read       (imem_read),
        .imem_read_valid (imem_read_valid),
        .imem_last       (imem_last),
        .dmem_req        (dmem_req),
        .dmem_write      (dmem_write),
        .dmem_write_req  (dmem_write_req),
        .dmem_read       (dmem_read),
        .dmem_read_valid (dmem_read_valid),
        .dmem_last       (dmem_last),
        .flash_index     (flash_index),
        .flash_word      (flash_word),
        .boot_done       (boot_done)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Flash contents mixed from every index bit
    function automatic word_t flash_image(input addr_t index);
        word_t mixed;
        mixed = word_t'(index) * 32'h9e37_79b1;
        return mixed ^ {index, 20'h5_a3c1} ^ 32'h0f96_c3a5;
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        return shadow[addr];
    endfunction

    assign flash_word = flash_image(flash_index);

    // Write word for the current beat, taken by the RAM on write_req
    assign dmem_write = shadow[{dmem_req.addr[ADDR_W-1:OFFS_W], dbeat}];

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, beat counters, timeout
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Beat counters wrap to 0 after each full burst
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (imem_read_valid) begin
            ibeat <= ibeat + 1'b1;
        end
        if (dmem_read_valid || dmem_write_req) begin
            dbeat <= dbeat + 1'b1;
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout, no finish after %0d cycles", cycle_cnt));
        end
    end

    // Outputs sampled mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (boot_seen && !boot_done) begin
                report_error("boot_done fell after rising");
            end
            boot_seen = boot_seen | boot_done;
            if (!boot_done && (imem_read_valid || imem_last || dmem_read_valid
                               || dmem_write_req || dmem_last)) begin
                report_error("cache port strobe seen before boot_done");
            end
            if (imem_last && !imem_read_valid) begin
                report_error("imem_last without a read beat");
            end
            if (dmem_last && !(dmem_read_valid || dmem_write_req)) begin
                report_error("dmem_last without a beat");
            end
            if (imem_read_valid) begin
                if (!imem_req.op || i_done) begin
                    report_error("imem read beat outside a burst");
                end
                check_word("imem_read",
                           expected_word({imem_req.addr[ADDR_W-1:OFFS_W], ibeat}),
                           imem_read);
                check_flag("imem_last", ibeat == offs_t'(LAST_BEAT), imem_last);
            end
            if (dmem_read_valid || dmem_write_req) begin
                if (!dmem_req.op || d_done) begin
                    report_error("dmem beat outside a burst");
                end
                if (dmem_req.rw ? dmem_read_valid : dmem_write_req) begin
                    report_error("dmem beat in the wrong direction");
                end
                if (dmem_read_valid) begin
                    check_word("dmem_read",
                               expected_word({dmem_req.addr[ADDR_W-1:OFFS_W], dbeat}),
                               dmem_read);
                end
                check_flag("dmem_last", dbeat == offs_t'(LAST_BEAT), dmem_last);
            end
            // Burst bookkeeping for the stimulus side
            if (imem_last) begin
                i_done = 1'b1;
                i_last_cnt = i_last_cnt + 1;
                i_last_cyc = cycle_cnt;
            end else if (!imem_req.op) begin
                i_done = 1'b0;
            end
            if (dmem_last) begin
                d_done = 1'b1;
                d_last_cnt = d_last_cnt + 1;
                d_last_cyc = cycle_cnt;
            end else if (!dmem_req.op) begin
                d_done = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic int rand_block();
        return BOOT_BLOCKS + int'($urandom % (NUM_BLOCKS - BOOT_BLOCKS));
    endfunction

    task automatic issue_imem(input int blk);
        imem_req.op   = 1'b1;
        // Port ignores rw, so odd blocks set it
        imem_req.rw   = (blk % 2) == 1;
        imem_req.addr = addr_t'(blk * BLOCK_WORDS);
        i_mark = i_last_cnt;
        i_req_cyc = cycle_cnt;
    endtask

    // Write data lands in the model before the request
    task automatic issue_dmem(input int blk, input logic wr);
        if (wr) begin
            for (int k = 0; k < BLOCK_WORDS; k++) begin
                shadow[blk * BLOCK_WORDS + k] = $urandom;
            end
        end
        dmem_req.op   = 1'b1;
        dmem_req.rw   = wr;
        dmem_req.addr = addr_t'(blk * BLOCK_WORDS);
        d_mark = d_last_cnt;
        d_req_cyc = cycle_cnt;
    endtask

    // Each request dropped in the cycle after its last strobe
    task automatic finish_bursts();
        while (imem_req.op || dmem_req.op) begin
            step();
            if (imem_req.op && i_last_cnt != i_mark) begin
                imem_req = '0;
            end
            if (dmem_req.op && d_last_cnt != d_mark) begin
                dmem_req = '0;
            end
        end
    endtask

    task automatic imem_read_block(input int blk);
        step();
        issue_imem(blk);
        finish_bursts();
        check_count("imem latency", LATENCY, i_last_cyc - i_req_cyc + 1);
    endtask

    task automatic dmem_block(input int blk, input logic wr);
        step();
        issue_dmem(blk, wr);
        finish_bursts();
        check_count("dmem latency", LATENCY, d_last_cyc - d_req_cyc + 1);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        imem_req = '0;
        dmem_req = '0;
        for (int a = 0; a < 2 ** ADDR_W; a++) begin
            shadow[a] = (a < BOOT_BLOCKS * BLOCK_WORDS) ? flash_image(addr_t'(a)) : '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("boot_done", 1'b0, boot_done);

        // Cache requests during the final boot burst
        // Between boot bursts the loader request is low for one idle cycle
        while (flash_index[ADDR_W-1:OFFS_W] != BLK_W'(BOOT_BLOCKS - 1)) begin
            step();
        end
        step();
        step();
        check_flag("boot_done", 1'b0, boot_done);
        last_blk = rand_block();
        issue_imem(0);
        issue_dmem(last_blk, 1'b1);
        while (!boot_done) begin
            step();
        end
        finish_bursts();
        check_flag("imem_last_first", 1'b1, i_last_cyc < d_last_cyc);

        // Boot image readback
        for (int b = 0; b < BOOT_BLOCKS; b++) begin
            imem_read_block(b);
        end

        // Random blocks above the boot image
        for (int n = 0; n < RAND_PAIRS; n++) begin
            last_blk = rand_block();
            dmem_block(last_blk, 1'b1);
            dmem_block(last_blk, 1'b0);
        end

        // Overwrite boot block 2 and read it back on the instruction side
        dmem_block(2, 1'b1);
        imem_read_block(2);

        // Same-cycle requests where the instruction cache wins
        step();
        issue_imem(1);
        issue_dmem(last_blk, 1'b0);
        finish_bursts();
        check_flag("imem_last_first", 1'b1, i_last_cyc < d_last_cyc);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
